/* src/exec_pkg.sv */
package exec_pkg;

    // --------------------------------------------------------------------
    // Data and bus widths.
    // --------------------------------------------------------------------
    localparam int XLEN  = 64;
    localparam int WLEN  = 32;
    localparam int OP_W  = 5;
    localparam int ADR_W = 3;

    // Shift amount widths for full and word operations.
    localparam int SH_W  = $clog2(XLEN);
    localparam int SHW_W = $clog2(WLEN);

    // Multiplier bit counter, must hold XLEN.
    localparam int CNT_W = $clog2(XLEN + 1);

    // --------------------------------------------------------------------
    // Operation codes.
    // --------------------------------------------------------------------
    typedef enum logic [OP_W-1:0] {
        ADD   = 5'd0,
        SUB   = 5'd1,
        AND   = 5'd2,
        OR    = 5'd3,
        XOR   = 5'd4,
        SLL   = 5'd5,
        SLT   = 5'd6,
        SLTU  = 5'd7,
        SRL   = 5'd8,
        SRA   = 5'd9,
        ADDW  = 5'd10,
        SUBW  = 5'd11,
        SLLW  = 5'd12,
        SRLW  = 5'd13,
        SRAW  = 5'd14,
        ADDIW = 5'd15,
        // Handled by the multiplier.
        MUL   = 5'd16,
        MULW  = 5'd17
    } alu_op_e;

    // Request to the execute block.
    typedef struct packed {
        alu_op_e         op;
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
    } exec_req_t;

    // Result and comparison flags.
    typedef struct packed {
        logic [XLEN-1:0] result;
        logic            zero;
        logic            lt;
        logic            ltu;
    } exec_rsp_t;

    // --------------------------------------------------------------------
    // Register map and status bits.
    // --------------------------------------------------------------------
    localparam logic [ADR_W-1:0] REG_SRC1   = 3'd0;
    localparam logic [ADR_W-1:0] REG_SRC2   = 3'd1;
    localparam logic [ADR_W-1:0] REG_OP     = 3'd2;
    localparam logic [ADR_W-1:0] REG_RESULT = 3'd3;
    localparam logic [ADR_W-1:0] REG_STATUS = 3'd4;

    localparam int ST_BUSY = 0;
    localparam int ST_ZERO = 1;
    localparam int ST_LT   = 2;
    localparam int ST_LTU  = 3;

    // Sign-extend a word result to XLEN.
    function automatic logic [XLEN-1:0] sext_w(input logic [WLEN-1:0] w);
        return {{(XLEN - WLEN){w[WLEN-1]}}, w};
    endfunction

endpackage

/* src/alu.sv */
`timescale 1ns/1ps

module alu
    import exec_pkg::*;
(
    // Operation select.
    input  alu_op_e         i_alu_control,

    // Operands.
    input  logic [XLEN-1:0] i_src_1,
    input  logic [XLEN-1:0] i_src_2,

    // Result and flags.
    output logic [XLEN-1:0] o_alu_result,
    output logic            o_zero_flag,
    output logic            o_lt_flag,
    output logic            o_ltu_flag
);

    // --------------------------------------------------------------------
    // Candidate results.
    // --------------------------------------------------------------------

    // Full width operations.
    logic [XLEN-1:0] add_out;
    logic [XLEN-1:0] sub_out;
    logic [XLEN-1:0] and_out;
    logic [XLEN-1:0] or_out;
    logic [XLEN-1:0] xor_out;
    logic [XLEN-1:0] sll_out;
    logic [XLEN-1:0] srl_out;
    logic [XLEN-1:0] sra_out;

    // Word operations, extended at the mux.
    logic [WLEN-1:0] addw_out;
    logic [WLEN-1:0] subw_out;
    logic [WLEN-1:0] sllw_out;
    logic [WLEN-1:0] srlw_out;
    logic [WLEN-1:0] sraw_out;

    // Source comparisons.
    logic less_than;
    logic less_than_u;

    assign add_out = i_src_1 + i_src_2;
    assign sub_out = i_src_1 - i_src_2;
    assign and_out = i_src_1 & i_src_2;
    assign or_out  = i_src_1 | i_src_2;
    assign xor_out = i_src_1 ^ i_src_2;

    // Shift amounts use only the low 6 bits.
    assign sll_out = i_src_1 << i_src_2[SH_W-1:0];
    assign srl_out = i_src_1 >> i_src_2[SH_W-1:0];
    assign sra_out = $unsigned($signed(i_src_1) >>> i_src_2[SH_W-1:0]);

    // Word forms see the low 32 bits and a 5-bit shift.
    assign addw_out = i_src_1[WLEN-1:0] + i_src_2[WLEN-1:0];
    assign subw_out = i_src_1[WLEN-1:0] - i_src_2[WLEN-1:0];
    assign sllw_out = i_src_1[WLEN-1:0] << i_src_2[SHW_W-1:0];
    assign srlw_out = i_src_1[WLEN-1:0] >> i_src_2[SHW_W-1:0];
    assign sraw_out = $unsigned($signed(i_src_1[WLEN-1:0]) >>> i_src_2[SHW_W-1:0]);

    assign less_than   = $signed(i_src_1) < $signed(i_src_2);
    assign less_than_u = i_src_1 < i_src_2;

    // --------------------------------------------------------------------
    // Flags.
    // --------------------------------------------------------------------
    assign o_zero_flag = ~|o_alu_result;
    assign o_lt_flag   = less_than;
    assign o_ltu_flag  = less_than_u;

    // --------------------------------------------------------------------
    // Result mux.
    // --------------------------------------------------------------------
    always_comb begin
        o_alu_result = '0;

        case (i_alu_control)
            ADD:   o_alu_result = add_out;
            SUB:   o_alu_result = sub_out;
            AND:   o_alu_result = and_out;
            OR:    o_alu_result = or_out;
            XOR:   o_alu_result = xor_out;
            SLL:   o_alu_result = sll_out;
            SLT:   o_alu_result = {{(XLEN - 1){1'b0}}, less_than};
            SLTU:  o_alu_result = {{(XLEN - 1){1'b0}}, less_than_u};
            SRL:   o_alu_result = srl_out;
            SRA:   o_alu_result = sra_out;

            ADDW:  o_alu_result = sext_w(addw_out);
            SUBW:  o_alu_result = sext_w(subw_out);
            SLLW:  o_alu_result = sext_w(sllw_out);
            SRLW:  o_alu_result = sext_w(srlw_out);
            SRAW:  o_alu_result = sext_w(sraw_out);

            // Immediate word add, truncated.
            ADDIW: o_alu_result = sext_w(add_out[WLEN-1:0]);

            // Multiply and unused codes.
            default: o_alu_result = '0;
        endcase
    end

endmodule

/* src/mul_unit.sv */
`timescale 1ns/1ps

module mul_unit
    import exec_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst_n,

    // Request.
    input  logic            i_start,
    input  logic            i_word,
    input  logic [XLEN-1:0] i_src_1,
    input  logic [XLEN-1:0] i_src_2,

    // Result.
    output logic [XLEN-1:0] o_product,
    output logic            o_done
);

    // Partial product and shifting operands.
    logic [XLEN-1:0]  acc;
    logic [XLEN-1:0]  mcand;
    logic [XLEN-1:0]  mplier;

    // Control.
    logic [CNT_W-1:0] count;
    logic             busy;
    logic             word_q;

    // Operands of the current step.
    logic [XLEN-1:0]  step_acc;
    logic [XLEN-1:0]  step_mcand;
    logic [XLEN-1:0]  step_mplier;

    // A start feeds fresh operands into the first step.
    assign step_acc    = i_start ? '0      : acc;
    assign step_mcand  = i_start ? i_src_1 : mcand;
    assign step_mplier = i_start ? i_src_2 : mplier;

    // --------------------------------------------------------------------
    // Shift-add datapath.
    // --------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_start || busy) begin
            acc    <= step_mplier[0] ? step_acc + step_mcand : step_acc;
            mcand  <= step_mcand << 1;
            mplier <= step_mplier >> 1;
        end
    end

    // --------------------------------------------------------------------
    // Bit counter.
    // --------------------------------------------------------------------

    // First step runs on the start edge.
    // Counter holds the steps left after it.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy   <= 1'b0;
            count  <= '0;
            word_q <= 1'b0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                busy   <= 1'b1;
                word_q <= i_word;
                count  <= i_word ? CNT_W'(WLEN - 1) : CNT_W'(XLEN - 1);
            end else if (busy) begin
                count <= count - 1'b1;
                // Last step.
                if (count == CNT_W'(1)) begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    // Low word only for MULW.
    assign o_product = word_q ? sext_w(acc[WLEN-1:0]) : acc;

    // --------------------------------------------------------------------
    // Assertions.
    // --------------------------------------------------------------------
    a_no_start_busy: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) i_start |-> !busy
    );

    a_done_pulse: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) o_done |=> !o_done
    );

endmodule

/* src/result_select.sv */
`timescale 1ns/1ps

module result_select
    import exec_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,

    // Request from the register block.
    input  exec_req_t i_req,
    input  logic      i_req_valid,

    // Registered response.
    output exec_rsp_t o_rsp,
    output logic      o_rsp_valid
);

    typedef enum logic {
        S_IDLE,
        S_MUL
    } sel_state_e;

    sel_state_e      state;

    // Decoded request.
    logic            is_mul;
    logic            is_word;
    logic            alu_take;
    logic            mul_start;

    // Engine outputs.
    logic [XLEN-1:0] alu_result;
    logic            alu_zero;
    logic            alu_lt;
    logic            alu_ltu;
    logic [XLEN-1:0] product;
    logic            mul_done;

    // Comparisons held for the multiply.
    logic            lt_q;
    logic            ltu_q;

    assign is_mul    = (i_req.op == MUL) || (i_req.op == MULW);
    assign is_word   = (i_req.op == MULW);
    assign alu_take  = i_req_valid && !is_mul;
    assign mul_start = i_req_valid && is_mul;

    // --------------------------------------------------------------------
    // Engines.
    // --------------------------------------------------------------------
    alu alu_inst (
        .i_alu_control (i_req.op),
        .i_src_1       (i_req.src1),
        .i_src_2       (i_req.src2),
        .o_alu_result  (alu_result),
        .o_zero_flag   (alu_zero),
        .o_lt_flag     (alu_lt),
        .o_ltu_flag    (alu_ltu)
    );

    mul_unit mul_unit_inst (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_start   (mul_start),
        .i_word    (is_word),
        .i_src_1   (i_req.src1),
        .i_src_2   (i_req.src2),
        .o_product (product),
        .o_done    (mul_done)
    );

    // --------------------------------------------------------------------
    // Control.
    // --------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= S_IDLE;
            o_rsp_valid <= 1'b0;
        end else begin
            o_rsp_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (alu_take) begin
                        o_rsp_valid <= 1'b1;
                    end else if (mul_start) begin
                        state <= S_MUL;
                    end
                end
                S_MUL: begin
                    if (mul_done) begin
                        state       <= S_IDLE;
                        o_rsp_valid <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Response payload.
    always_ff @(posedge i_clk) begin
        if (mul_start) begin
            lt_q  <= alu_lt;
            ltu_q <= alu_ltu;
        end
        if (alu_take) begin
            o_rsp <= '{result: alu_result, zero: alu_zero, lt: alu_lt, ltu: alu_ltu};
        end else if (mul_done) begin
            o_rsp <= '{result: product, zero: ~|product, lt: lt_q, ltu: ltu_q};
        end
    end

    // --------------------------------------------------------------------
    // Assertions.
    // --------------------------------------------------------------------

    // Multiplier answers only while a multiply is pending.
    a_done_in_mul: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) mul_done |-> state == S_MUL
    );

endmodule

/* src/wb_regs.sv */
`timescale 1ns/1ps

module wb_regs
    import exec_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst_n,

    // Wishbone classic slave.
    input  logic             i_wb_cyc,
    input  logic             i_wb_stb,
    input  logic             i_wb_we,
    input  logic [ADR_W-1:0] i_wb_adr,
    input  logic [XLEN-1:0]  i_wb_dat,
    output logic [XLEN-1:0]  o_wb_dat,
    output logic             o_wb_ack,

    // Request out.
    output exec_req_t        o_req,
    output logic             o_req_valid,

    // Response in.
    input  exec_rsp_t        i_rsp,
    input  logic             i_rsp_valid
);

    // Operand and operation registers.
    exec_req_t       req_q;
    // Result and flag registers.
    exec_rsp_t       rsp_q;
    logic            busy;

    logic            wb_req;
    logic            wr_en;
    logic [XLEN-1:0] status;
    logic [XLEN-1:0] rd_data;

    // New request only when no ack is out.
    assign wb_req = i_wb_cyc && i_wb_stb && !o_wb_ack;
    assign wr_en  = wb_req && i_wb_we;

    assign o_req = req_q;

    // --------------------------------------------------------------------
    // Read path.
    // --------------------------------------------------------------------
    always_comb begin
        status          = '0;
        status[ST_BUSY] = busy;
        status[ST_ZERO] = rsp_q.zero;
        status[ST_LT]   = rsp_q.lt;
        status[ST_LTU]  = rsp_q.ltu;
    end

    always_comb begin
        case (i_wb_adr)
            REG_SRC1:   rd_data = req_q.src1;
            REG_SRC2:   rd_data = req_q.src2;
            REG_OP:     rd_data = {{(XLEN - OP_W){1'b0}}, req_q.op};
            REG_RESULT: rd_data = rsp_q.result;
            REG_STATUS: rd_data = status;
            default:    rd_data = '0;
        endcase
    end

    // Single-cycle ack with data.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_ack <= 1'b0;
            o_wb_dat <= '0;
        end else begin
            o_wb_ack <= wb_req;
            if (wb_req && !i_wb_we) begin
                o_wb_dat <= rd_data;
            end
        end
    end

    // --------------------------------------------------------------------
    // Register writes and operation launch.
    // --------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            req_q       <= '{op: ADD, src1: '0, src2: '0};
            rsp_q       <= '0;
            busy        <= 1'b0;
            o_req_valid <= 1'b0;
        end else begin
            o_req_valid <= 1'b0;
            if (wr_en) begin
                case (i_wb_adr)
                    REG_SRC1: req_q.src1 <= i_wb_dat;
                    REG_SRC2: req_q.src2 <= i_wb_dat;
                    REG_OP: begin
                        // Dropped while an operation runs.
                        if (!busy) begin
                            req_q.op    <= alu_op_e'(i_wb_dat[OP_W-1:0]);
                            o_req_valid <= 1'b1;
                            busy        <= 1'b1;
                        end
                    end
                    // Result and status are read only.
                    default: ;
                endcase
            end
            if (i_rsp_valid) begin
                rsp_q <= i_rsp;
                busy  <= 1'b0;
            end
        end
    end

    // --------------------------------------------------------------------
    // Assertions.
    // --------------------------------------------------------------------
    a_ack_pulse: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) o_wb_ack |=> !o_wb_ack
    );

    // Responses only return for a launched operation.
    a_rsp_when_busy: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) i_rsp_valid |-> busy
    );

endmodule

/* src/exec_top.sv */
`timescale 1ns/1ps

module exec_top
    import exec_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst_n,

    // Wishbone classic slave.
    input  logic             i_wb_cyc,
    input  logic             i_wb_stb,
    input  logic             i_wb_we,
    input  logic [ADR_W-1:0] i_wb_adr,
    input  logic [XLEN-1:0]  i_wb_dat,
    output logic [XLEN-1:0]  o_wb_dat,
    output logic             o_wb_ack
);

    // --------------------------------------------------------------------
    // Register block to combiner.
    // --------------------------------------------------------------------
    exec_req_t req;
    logic      req_valid;
    exec_rsp_t rsp;
    logic      rsp_valid;

    // Host registers and bus.
    wb_regs wb_regs_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wb_cyc    (i_wb_cyc),
        .i_wb_stb    (i_wb_stb),
        .i_wb_we     (i_wb_we),
        .i_wb_adr    (i_wb_adr),
        .i_wb_dat    (i_wb_dat),
        .o_wb_dat    (o_wb_dat),
        .o_wb_ack    (o_wb_ack),
        .o_req       (req),
        .o_req_valid (req_valid),
        .i_rsp       (rsp),
        .i_rsp_valid (rsp_valid)
    );

    // ALU and multiplier behind one response.
    result_select result_select_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req       (req),
        .i_req_valid (req_valid),
        .o_rsp       (rsp),
        .o_rsp_valid (rsp_valid)
    );

endmodule

/* test/tb_exec_top.sv */
`timescale 1ns/1ps

module tb_exec_top
    import exec_pkg::*;
();

    // ------------------------------------------------------------------
    // Test sizes and limits.
    // ------------------------------------------------------------------
    localparam int N_EDGE     = 5;
    localparam int N_PAIRS    = 8;
    localparam int N_MUL      = 6;
    localparam int N_OPS      = 16 * N_PAIRS + 2 * N_MUL + 2;
    localparam int ACK_LIMIT  = 4;
    localparam int POLL_LIMIT = XLEN + 20;
    localparam int WD_CYCLES  = N_OPS * (XLEN + 20) + 500;

    logic             i_clk;
    logic             i_rst_n;
    logic             i_wb_cyc;
    logic             i_wb_stb;
    logic             i_wb_we;
    logic [ADR_W-1:0] i_wb_adr;
    logic [XLEN-1:0]  i_wb_dat;
    logic [XLEN-1:0]  o_wb_dat;
    logic             o_wb_ack;

    // Expected read data, latched by the read task.
    logic             rd_check;
    logic [XLEN-1:0]  rd_exp;
    int               value_errs;
    int               proto_errs;
    logic [15:0]      lfsr;

    // Edge operands: zero, all ones, minimum signed, masked shifts.
    logic [XLEN-1:0] edge_a [N_EDGE] = '{64'h0, 64'hFFFF_FFFF_FFFF_FFFF,
        64'h8000_0000_0000_0000, 64'h1, 64'h8000_0000_8000_0000};
    logic [XLEN-1:0] edge_b [N_EDGE] = '{64'h0, 64'h1,
        64'hFFFF_FFFF_FFFF_FFFF, 64'h8000_0000_0000_0000, 64'h7F};

    exec_top exec_top_inst (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // ------------------------------------------------------------------
    // Bus checks.
    // ------------------------------------------------------------------
    a_ack_next: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_wb_cyc && i_wb_stb && !o_wb_ack) |=> o_wb_ack)
    else begin
        $display("Request at address %0d was not acknowledged on the next cycle",
                 $sampled(i_wb_adr));
        proto_errs++;
    end

    a_ack_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_ack |=> !o_wb_ack)
    else begin
        $display("Ack stayed high for more than one cycle");
        proto_errs++;
    end

    a_read_data: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_wb_ack && rd_check) |-> (o_wb_dat == rd_exp))
    else begin
        $display("ERROR: o_wb_dat = %h, expected %h at address %0d",
                 $sampled(o_wb_dat), rd_exp, $sampled(i_wb_adr));
        value_errs++;
    end

    // ------------------------------------------------------------------
    // Random operands.
    // ------------------------------------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        // Taps 16, 14, 13, 11.
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per operand bit.
    function automatic logic [XLEN-1:0] rand_word();
        logic [XLEN-1:0] r;
        for (int i = 0; i < XLEN; i++) begin
            lfsr = lfsr_next(lfsr);
            r[i] = lfsr[0];
        end
        return r;
    endfunction

    // ------------------------------------------------------------------
    // Reference model.
    // ------------------------------------------------------------------
    function automatic exec_rsp_t model(input logic [OP_W-1:0] op,
                                        input logic [XLEN-1:0] a,
                                        input logic [XLEN-1:0] b);
        logic [XLEN-1:0] r;
        logic [WLEN-1:0] w;
        logic            is_w;
        logic [5:0]      sh;
        logic [4:0]      shw;
        exec_rsp_t       rsp;
        sh   = b[5:0];
        shw  = b[4:0];
        r    = '0;
        w    = '0;
        is_w = 1'b0;
        case (op)
            ADD:  r = a + b;
            SUB:  r = a - b;
            AND:  r = a & b;
            OR:   r = a | b;
            XOR:  r = a ^ b;
            SLL:  r = a << sh;
            SLT:  r = {63'b0, $signed(a) < $signed(b)};
            SLTU: r = {63'b0, a < b};
            SRL:  r = a >> sh;
            // Arithmetic shift as logical shift plus sign fill.
            SRA:  r = (a >> sh) | (a[63] ? ~({XLEN{1'b1}} >> sh) : '0);
            MUL:  r = a * b;
            default: begin
                is_w = 1'b1;
                case (op)
                    ADDW, ADDIW: w = a[31:0] + b[31:0];
                    SUBW: w = a[31:0] - b[31:0];
                    SLLW: w = a[31:0] << shw;
                    SRLW: w = a[31:0] >> shw;
                    SRAW: w = (a[31:0] >> shw) | (a[31] ? ~(32'hFFFF_FFFF >> shw) : '0);
                    MULW: w = a[31:0] * b[31:0];
                    // Unused codes.
                    default: is_w = 1'b0;
                endcase
            end
        endcase
        if (is_w) begin
            r = {{32{w[31]}}, w};
        end
        rsp.result = r;
        rsp.zero   = (r == '0);
        rsp.lt     = $signed(a) < $signed(b);
        rsp.ltu    = a < b;
        return rsp;
    endfunction

    // ------------------------------------------------------------------
    // Wishbone master tasks.
    // ------------------------------------------------------------------
    task automatic wait_ack();
        int n;
        n = 0;
        do begin
            @(negedge i_clk);
            n++;
        end while (!o_wb_ack && n < ACK_LIMIT);
        if (!o_wb_ack) begin
            $display("No ack came for the request at address %0d", i_wb_adr);
            proto_errs++;
        end
    endtask

    task automatic bus_write(input logic [ADR_W-1:0] adr, input logic [XLEN-1:0] dat);
        @(negedge i_clk);
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = 1'b1;
        i_wb_adr = adr;
        i_wb_dat = dat;
        wait_ack();
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
    endtask

    task automatic bus_read(input logic [ADR_W-1:0] adr, input logic check,
                            input logic [XLEN-1:0] exp, output logic [XLEN-1:0] data);
        @(negedge i_clk);
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = 1'b0;
        i_wb_adr = adr;
        rd_check = check;
        rd_exp   = exp;
        wait_ack();
        data     = o_wb_dat;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        // The ack is sampled on the next rising edge.
        @(negedge i_clk);
        rd_check = 1'b0;
    endtask

    // Poll STATUS until busy clears.
    task automatic wait_idle(output logic saw_busy);
        int              polls;
        logic [XLEN-1:0] st;
        saw_busy = 1'b0;
        polls    = 0;
        do begin
            bus_read(REG_STATUS, 1'b0, '0, st);
            saw_busy |= st[ST_BUSY];
            polls++;
        end while (st[ST_BUSY] && polls < POLL_LIMIT);
        if (st[ST_BUSY]) begin
            $display("Busy flag never cleared after %0d status reads", polls);
            proto_errs++;
        end
    endtask

    // Load operands, launch, wait and check RESULT and STATUS.
    task automatic run_op(input logic [OP_W-1:0] op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, input logic is_long);
        exec_rsp_t       exp;
        logic            saw_busy;
        logic [XLEN-1:0] d;
        logic [XLEN-1:0] st_exp;
        exp = model(op, a, b);
        bus_write(REG_SRC1, a);
        bus_write(REG_SRC2, b);
        bus_write(REG_OP, {{(XLEN - OP_W){1'b0}}, op});
        wait_idle(saw_busy);
        if (is_long) begin
            a_busy_seen: assert (saw_busy) else begin
                $display("Busy was never seen set during multiply op %0d", op);
                proto_errs++;
            end
        end
        st_exp          = '0;
        st_exp[ST_ZERO] = exp.zero;
        st_exp[ST_LT]   = exp.lt;
        st_exp[ST_LTU]  = exp.ltu;
        bus_read(REG_RESULT, 1'b1, exp.result, d);
        bus_read(REG_STATUS, 1'b1, st_exp, d);
    endtask

    // ------------------------------------------------------------------
    // Watchdog.
    // ------------------------------------------------------------------
    initial begin
        repeat (WD_CYCLES) @(posedge i_clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WD_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    // ------------------------------------------------------------------
    // Main sequence.
    // ------------------------------------------------------------------
    initial begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] d;
        logic            saw_busy;
        exec_rsp_t       exp;
        i_rst_n    = 1'b0;
        i_wb_cyc   = 1'b0;
        i_wb_stb   = 1'b0;
        i_wb_we    = 1'b0;
        i_wb_adr   = '0;
        i_wb_dat   = '0;
        rd_check   = 1'b0;
        rd_exp     = '0;
        value_errs = 0;
        proto_errs = 0;
        lfsr       = 16'd45738;
        repeat (2) @(negedge i_clk);
        i_rst_n = 1'b1;

        // Every register reads zero after reset, busy included.
        for (int r = 0; r < 8; r++) begin
            bus_read(ADR_W'(r), 1'b1, '0, d);
        end

        // All sixteen ALU operations, edge pairs first.
        for (int op = 0; op < 16; op++) begin
            for (int k = 0; k < N_PAIRS; k++) begin
                a = (k < N_EDGE) ? edge_a[k] : rand_word();
                b = (k < N_EDGE) ? edge_b[k] : rand_word();
                run_op(OP_W'(op), a, b, 1'b0);
            end
        end

        // Multiplies.
        for (int k = 0; k < N_MUL; k++) begin
            run_op(MUL, rand_word(), rand_word(), 1'b1);
            run_op(MULW, rand_word(), rand_word(), 1'b1);
        end

        // Second OP write during a MUL is dropped.
        a = rand_word();
        b = rand_word();
        exp = model(MUL, a, b);
        bus_write(REG_SRC1, a);
        bus_write(REG_SRC2, b);
        bus_write(REG_OP, {{(XLEN - OP_W){1'b0}}, MUL});
        bus_write(REG_OP, {{(XLEN - OP_W){1'b0}}, ADD});
        wait_idle(saw_busy);
        bus_read(REG_RESULT, 1'b1, exp.result, d);
        bus_read(REG_OP, 1'b1, {{(XLEN - OP_W){1'b0}}, MUL}, d);

        // Unused code gives zero.
        run_op(5'd31, rand_word(), rand_word(), 1'b0);

        repeat (2) @(negedge i_clk);
        $display("Value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
src/exec_pkg.sv
src/alu.sv
src/mul_unit.sv
src/result_select.sv
src/wb_regs.sv
src/exec_top.sv
test/tb_exec_top.sv
